//--- hw/l2CachePkg.sv
/*
  Shared types for the L2 tag and state controller.
  Addresses are 32 bits with 64-byte lines. Only MESI state is kept, no line data.
*/
package l2CachePkg;

  parameter int addrWidth  = 32;
  parameter int maxWayBits = 3;   // Enough for 8 ways

  // ****************************************
  // Encodings
  // ****************************************
  typedef enum logic [2:0] {
    opDataRead,
    opDataWrite,
    opInstrRead,
    opSnoopRead,
    opSnoopWrite,
    opSnoopInvalidate,
    opSnoopRfo,
    opClear
  } cacheOpT;

  typedef enum logic [1:0] {stateI, stateS, stateE, stateM} mesiT;

  typedef enum logic [1:0] {busNone, busRead, busRfo, busInvalidate} busOpT;

  // Same coding for snoop results seen and snoop replies given
  typedef enum logic [1:0] {snoopMiss, snoopHit, snoopHitM} snoopResultT;

  // ****************************************
  // Request and response
  // ****************************************
  typedef struct packed {
    cacheOpT                op;
    logic [addrWidth-1:0]   addr;
    snoopResultT            snoopIn;   // Only looked at on processor misses
  } cacheReqT;

  typedef struct packed {
    cacheOpT                op;
    logic                   hit;
    logic [maxWayBits-1:0]  way;
    mesiT                   newState;
    busOpT                  busOp;
    snoopResultT            snoopOut;
    logic                   evictDirty;  // Victim held M before the fill
  } cacheRspT;

endpackage

//--- hw/requestQueue.sv
/*
  Request FIFO under credit flow control. The requester owns queueDepth credits,
  so a push into a full queue is a protocol error and is never refused here.
*/
`timescale 1ns/10ps

module requestQueue import l2CachePkg::*; #(
  parameter int queueDepth = 4
) (
  input  logic     clk,
  input  logic     arstN,
  input  logic     reqValid,
  input  cacheReqT req,
  output cacheReqT head,
  output logic     headValid,
  output logic     creditReturn
);

  localparam int ptrBits = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int cntBits = $clog2(queueDepth + 1);

  cacheReqT           mem [queueDepth];
  logic [ptrBits-1:0] wrPtr;
  logic [ptrBits-1:0] rdPtr;
  logic [cntBits-1:0] count;
  logic               pop;

  function automatic logic [ptrBits-1:0] nextPtr(logic [ptrBits-1:0] p);
    return (p == ptrBits'(queueDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign headValid = (count != '0);
  assign head      = mem[rdPtr];
  assign pop       = headValid;   // Stages never stall

  always_ff @(posedge clk) begin
    if (reqValid) mem[wrPtr] <= req;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr        <= '0;
      rdPtr        <= '0;
      count        <= '0;
      creditReturn <= 1'b0;
    end else begin
      if (reqValid) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      count        <= count + cntBits'(reqValid) - cntBits'(pop);
      creditReturn <= pop;          // One credit back per entry popped
    end
  end

  // Requester spent a credit it did not have
  overflowChk: assert property (@(posedge clk) disable iff (!arstN)
    reqValid |-> count < cntBits'(queueDepth))
    else $error("request pushed into a full queue");

endmodule

//--- hw/tagLookup.sv
/*
  Tag and state arrays plus the lookup stage. A write or clear landing at the
  same edge as a lookup capture is forwarded, so the lookup sees the new values.
*/
`timescale 1ns/10ps

module tagLookup import l2CachePkg::*; #(
  parameter int ways    = 4,
  parameter int setBits = 4
) (
  input  logic                       clk,
  input  logic                       arstN,
  input  cacheReqT                   head,
  input  logic                       headValid,
  input  logic                       wrValid,
  input  logic [setBits-1:0]         wrSet,
  input  logic [$clog2(ways)-1:0]    wrWay,
  input  logic [addrWidth-setBits-7:0] wrTag,
  input  mesiT                       wrState,
  input  logic                       clearAll,
  output logic                       lookValid,
  output cacheReqT                   lookReq,
  output logic [ways-1:0]            hitWays,
  output mesiT [ways-1:0]            wayStates
);

  localparam int offsetBits = 6;
  localparam int tagBits    = addrWidth - setBits - offsetBits;
  localparam int wayBits    = $clog2(ways);
  localparam int sets       = 2 ** setBits;

  logic [ways-1:0][tagBits-1:0] tagMem [sets];
  mesiT [ways-1:0]              stateMem [sets];

  logic [setBits-1:0]           headSet;
  logic [tagBits-1:0]           headTag;
  logic [ways-1:0][tagBits-1:0] curTag;
  mesiT [ways-1:0]              curState;
  logic [ways-1:0]              curHit;

  assign headSet = head.addr[offsetBits +: setBits];
  assign headTag = head.addr[addrWidth-1 -: tagBits];

  // ****************************************
  // Arrays
  // ****************************************
  always_ff @(posedge clk) begin
    if (wrValid) tagMem[wrSet][wrWay] <= wrTag;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int s = 0; s < sets; s++) stateMem[s] <= {ways{stateI}};
    end else if (clearAll) begin
      for (int s = 0; s < sets; s++) stateMem[s] <= {ways{stateI}};
    end else if (wrValid) begin
      stateMem[wrSet][wrWay] <= wrState;
    end
  end

  // ****************************************
  // Compare with forwarding
  // ****************************************
  always_comb begin
    for (int w = 0; w < ways; w++) begin
      curTag[w]   = tagMem[headSet][w];
      curState[w] = stateMem[headSet][w];
      if (wrValid && wrSet == headSet && wrWay == wayBits'(w)) begin
        curTag[w]   = wrTag;
        curState[w] = wrState;
      end
      if (clearAll) curState[w] = stateI;
      curHit[w] = (curState[w] != stateI) && (curTag[w] == headTag);  // I never hits
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) lookValid <= 1'b0;
    else        lookValid <= headValid;
  end

  always_ff @(posedge clk) begin
    lookReq   <= head;
    hitWays   <= curHit;
    wayStates <= curState;
  end

  // A tag may live in only one valid way of a set
  oneHitChk: assert property (@(posedge clk) disable iff (!arstN)
    lookValid |-> $onehot0(hitWays))
    else $error("tag found in more than one way");

endmodule

//--- hw/lruTracker.sv
/*
  Age-based LRU. Ages per set always form a permutation of 0..ways-1,
  age 0 being the most recent. Victim is the first invalid way, else the oldest.
*/
`timescale 1ns/10ps

module lruTracker import l2CachePkg::*; #(
  parameter int ways    = 4,
  parameter int setBits = 4
) (
  input  logic                    clk,
  input  logic                    arstN,
  input  cacheReqT                head,
  input  logic                    headValid,
  input  logic                    touchValid,
  input  logic [setBits-1:0]      touchSet,
  input  logic [$clog2(ways)-1:0] touchWay,
  input  logic                    clearAll,
  input  mesiT [ways-1:0]         wayStates,
  output logic [$clog2(ways)-1:0] victimWay
);

  localparam int wayBits = $clog2(ways);
  localparam int sets    = 2 ** setBits;

  typedef logic [ways-1:0][wayBits-1:0] ageVecT;

  ageVecT             ageMem [sets];
  ageVecT             fwdAges;
  logic [setBits-1:0] headSet;
  logic [wayBits-1:0] oldestNext;
  logic [wayBits-1:0] oldestWay;

  function automatic ageVecT resetAges();
    ageVecT a;
    for (int w = 0; w < ways; w++) a[w] = wayBits'(w);
    return a;
  endfunction

  // Touched way becomes 0, every younger way ages by one
  function automatic ageVecT touchAges(ageVecT cur, logic [wayBits-1:0] way);
    ageVecT nxt;
    nxt = cur;
    for (int w = 0; w < ways; w++) begin
      if (cur[w] < cur[way]) nxt[w] = cur[w] + 1'b1;
    end
    nxt[way] = '0;
    return nxt;
  endfunction

  function automatic logic isPerm(ageVecT a);
    logic [ways-1:0] seen;
    seen = '0;
    for (int w = 0; w < ways; w++) seen[a[w]] = 1'b1;
    return &seen;
  endfunction

  assign headSet = head.addr[6 +: setBits];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int s = 0; s < sets; s++) ageMem[s] <= resetAges();
    end else if (clearAll) begin
      for (int s = 0; s < sets; s++) ageMem[s] <= resetAges();
    end else if (touchValid) begin
      ageMem[touchSet] <= touchAges(ageMem[touchSet], touchWay);
    end
  end

  // ****************************************
  // Victim choice
  // ****************************************
  always_comb begin
    if (clearAll)                                fwdAges = resetAges();
    else if (touchValid && touchSet == headSet)  fwdAges = touchAges(ageMem[headSet], touchWay);
    else                                         fwdAges = ageMem[headSet];
    oldestNext = '0;
    for (int w = 1; w < ways; w++) begin
      if (fwdAges[w] > fwdAges[oldestNext]) oldestNext = wayBits'(w);
    end
  end

  always_ff @(posedge clk) begin
    if (headValid) oldestWay <= oldestNext;  // Aligned with the lookup stage
  end

  // Lowest invalid way wins over the oldest one
  always_comb begin
    victimWay = oldestWay;
    for (int w = ways - 1; w >= 0; w--) begin
      if (wayStates[w] == stateI) victimWay = wayBits'(w);
    end
  end

  permChk: assert property (@(posedge clk) disable iff (!arstN)
    touchValid |=> isPerm(ageMem[$past(touchSet)]))
    else $error("set ages are no longer a permutation");

endmodule

//--- hw/mesiController.sv
/*
  Resolve stage. Decodes the lookup result into the MESI next state, bus op
  and snoop reply. Array write, LRU touch and clear all land at the resolve edge.
*/
`timescale 1ns/10ps

module mesiController import l2CachePkg::*; #(
  parameter int ways    = 4,
  parameter int setBits = 4
) (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         lookValid,
  input  cacheReqT                     lookReq,
  input  logic [ways-1:0]              hitWays,
  input  mesiT [ways-1:0]              wayStates,
  input  logic [$clog2(ways)-1:0]      victimWay,
  output logic                         wrValid,
  output logic [setBits-1:0]           wrSet,
  output logic [$clog2(ways)-1:0]      wrWay,
  output logic [addrWidth-setBits-7:0] wrTag,
  output mesiT                         wrState,
  output logic                         touchValid,
  output logic [setBits-1:0]           touchSet,
  output logic [$clog2(ways)-1:0]      touchWay,
  output logic                         clearAll,
  output logic                         rspValid,
  output cacheRspT                     rsp
);

  localparam int wayBits = $clog2(ways);
  localparam int tagBits = addrWidth - setBits - 6;

  logic               hit;
  logic [wayBits-1:0] hitIdx;
  logic [wayBits-1:0] useWay;
  mesiT               hitState;
  logic               isProc;
  logic               doWrite;
  cacheRspT           nextRsp;

  always_comb begin
    hitIdx = '0;
    for (int w = 0; w < ways; w++) begin
      if (hitWays[w]) hitIdx = wayBits'(w);
    end
  end

  assign hit      = |hitWays;
  assign hitState = wayStates[hitIdx];
  assign isProc   = (lookReq.op == opDataRead) || (lookReq.op == opDataWrite) ||
                    (lookReq.op == opInstrRead);

  // ****************************************
  // MESI rules
  // ****************************************
  always_comb begin
    nextRsp     = '0;
    nextRsp.op  = lookReq.op;
    nextRsp.hit = hit;
    useWay      = hitIdx;
    doWrite     = 1'b0;
    unique case (lookReq.op)
      opDataRead, opInstrRead: begin
        if (hit) begin
          nextRsp.newState = hitState;            // Read hit leaves state alone
        end else begin
          useWay             = victimWay;
          doWrite            = 1'b1;
          nextRsp.busOp      = busRead;
          nextRsp.newState   = (lookReq.snoopIn == snoopMiss) ? stateE : stateS;
          nextRsp.evictDirty = (wayStates[victimWay] == stateM);
        end
      end
      opDataWrite: begin
        doWrite          = 1'b1;
        nextRsp.newState = stateM;
        if (hit) begin
          nextRsp.busOp = (hitState == stateS) ? busInvalidate : busNone;
        end else begin
          useWay             = victimWay;
          nextRsp.busOp      = busRfo;
          nextRsp.evictDirty = (wayStates[victimWay] == stateM);
        end
      end
      opSnoopRead, opSnoopWrite, opSnoopInvalidate, opSnoopRfo: begin
        nextRsp.newState = stateI;                // Miss reply leaves arrays untouched
        if (hit) begin
          doWrite          = 1'b1;
          nextRsp.snoopOut = (hitState == stateM) ? snoopHitM : snoopHit;
          nextRsp.newState = (lookReq.op == opSnoopRead) ? stateS : stateI;
        end
      end
      opClear: nextRsp.newState = stateI;
    endcase
    nextRsp.way = maxWayBits'(useWay);
  end

  assign wrValid    = lookValid && doWrite;
  assign wrSet      = lookReq.addr[6 +: setBits];
  assign wrWay      = useWay;
  assign wrTag      = lookReq.addr[addrWidth-1 -: tagBits];
  assign wrState    = nextRsp.newState;
  assign touchValid = lookValid && isProc;   // Snoops never age the set
  assign touchSet   = wrSet;
  assign touchWay   = useWay;
  assign clearAll   = lookValid && (lookReq.op == opClear);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) rspValid <= 1'b0;
    else        rspValid <= lookValid;
  end

  always_ff @(posedge clk) begin
    if (lookValid) rsp <= nextRsp;
  end

  // A fill must leave a valid line and report it
  fillChk: assert property (@(posedge clk) disable iff (!arstN)
    (lookValid && isProc && !hit) |-> wrValid && wrState != stateI
      ##1 rspValid && rsp.newState != stateI)
    else $error("fill wrote an invalid state");

endmodule

//--- hw/l2CacheTop.sv
/*
  L2 tag/state controller top. Requests are credit based with queueDepth credits.
  Responses come out in order with no back-pressure. ways must be 2, 4 or 8.
*/
`timescale 1ns/10ps

module l2CacheTop import l2CachePkg::*; #(
  parameter int ways       = 4,
  parameter int setBits    = 4,
  parameter int queueDepth = 4
) (
  input  logic     clk,
  input  logic     arstN,
  input  logic     reqValid,
  input  cacheReqT req,
  output logic     creditReturn,
  output logic     rspValid,
  output cacheRspT rsp
);

  localparam int wayBits = $clog2(ways);
  localparam int tagBits = addrWidth - setBits - 6;

  // ****************************************
  // Stage wiring
  // ****************************************
  cacheReqT           head;
  logic               headValid;
  logic               lookValid;
  cacheReqT           lookReq;
  logic [ways-1:0]    hitWays;
  mesiT [ways-1:0]    wayStates;
  logic [wayBits-1:0] victimWay;

  // Resolve stage write-back and LRU touch
  logic               wrValid;
  logic [setBits-1:0] wrSet;
  logic [wayBits-1:0] wrWay;
  logic [tagBits-1:0] wrTag;
  mesiT               wrState;
  logic               touchValid;
  logic [setBits-1:0] touchSet;
  logic [wayBits-1:0] touchWay;
  logic               clearAll;

  requestQueue #(.queueDepth(queueDepth)) requestQueue_i (
    .clk, .arstN, .reqValid, .req, .head, .headValid, .creditReturn
  );

  tagLookup #(.ways(ways), .setBits(setBits)) tagLookup_i (
    .clk, .arstN, .head, .headValid,
    .wrValid, .wrSet, .wrWay, .wrTag, .wrState, .clearAll,
    .lookValid, .lookReq, .hitWays, .wayStates
  );

  lruTracker #(.ways(ways), .setBits(setBits)) lruTracker_i (
    .clk, .arstN, .head, .headValid,
    .touchValid, .touchSet, .touchWay, .clearAll, .wayStates, .victimWay
  );

  mesiController #(.ways(ways), .setBits(setBits)) mesiController_i (
    .clk, .arstN, .lookValid, .lookReq, .hitWays, .wayStates, .victimWay,
    .wrValid, .wrSet, .wrWay, .wrTag, .wrState,
    .touchValid, .touchSet, .touchWay, .clearAll,
    .rspValid, .rsp
  );

endmodule

//--- verification/l2CacheTb.sv
/*
  Testbench for l2CacheTop with 4 ways, 16 sets and a 4-entry queue.
  Requests stream under credits; responses are checked in order against the table.
*/
`timescale 1ns/10ps

module l2CacheTb import l2CachePkg::*; ();

  localparam int ways          = 4;
  localparam int setBits       = 4;
  localparam int queueDepth    = 4;
  localparam int tagBits       = addrWidth - setBits - 6;
  localparam int timeoutCycles = 50;

  typedef struct packed {
    cacheOpT              op;
    logic [tagBits-1:0]   tag;
    logic [setBits-1:0]   set;
    snoopResultT          snoopIn;
    cacheRspT             exp;
  } stepT;

  logic     clk;
  logic     arstN;
  logic     reqValid;
  cacheReqT req;
  logic     creditReturn;
  logic     rspValid;
  cacheRspT rsp;

  stepT steps [$];
  int   sentCount;
  int   returnedCount;
  int   rspIdx;
  int   curStep;
  int   burstStart;
  int   ageModel [ways];   // LRU ages of set 3
  bit   dirtyModel [ways]; // Set 3 ways holding M

  l2CacheTop #(.ways(ways), .setBits(setBits), .queueDepth(queueDepth)) l2CacheTop_i (
    .clk, .arstN, .reqValid, .req, .creditReturn, .rspValid, .rsp
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk or negedge arstN) begin
    if (!arstN) returnedCount <= 0;
    else if (creditReturn) returnedCount <= returnedCount + 1;
  end

  // ****************************************
  // Helpers
  // ****************************************
  task automatic stopWithFailure();
    $display("Test FAILED");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic checkEq(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s at response %0d: got 0x%0h, expected 0x%0h", name, curStep, got, exp);
      stopWithFailure();
    end
  endtask

  task automatic reportTimeout(string what);
    $display("Timed out after %0d cycles waiting for %s", timeoutCycles, what);
    stopWithFailure();
  endtask

  task automatic waitCycle();
    @(posedge clk);
    #1;
  endtask

  // Touched way goes to 0 and every younger way ages by one
  task automatic touchModel(int way);
    int oldAge;
    oldAge = ageModel[way];
    for (int w = 0; w < ways; w++) begin
      if (ageModel[w] < oldAge) ageModel[w]++;
    end
    ageModel[way] = 0;
  endtask

  function automatic int oldestModel();
    int oldest;
    oldest = 0;
    for (int w = 1; w < ways; w++) begin
      if (ageModel[w] > ageModel[oldest]) oldest = w;
    end
    return oldest;
  endfunction

  task automatic addStep(cacheOpT op, int tag, int set, snoopResultT snoopIn, bit hit,
                         int way, mesiT newState, busOpT busOp, snoopResultT snoopOut,
                         bit evictDirty);
    stepT s;
    s.op             = op;
    s.tag            = tagBits'(tag);
    s.set            = setBits'(set);
    s.snoopIn        = snoopIn;
    s.exp.op         = op;
    s.exp.hit        = hit;
    s.exp.way        = maxWayBits'(way);
    s.exp.newState   = newState;
    s.exp.busOp      = busOp;
    s.exp.snoopOut   = snoopOut;
    s.exp.evictDirty = evictDirty;
    steps.push_back(s);
  endtask

  // ****************************************
  // Stimulus and expected responses
  // ****************************************
  task automatic buildTable();
    int victimA;
    int victimB;
    for (int w = 0; w < ways; w++) begin
      ageModel[w]   = w;
      dirtyModel[w] = 1'b0;
    end
    // Read fills, read hit, instruction fill in S
    addStep(opDataRead,  'h1, 1, snoopMiss, 0, 0, stateE, busRead, snoopMiss, 0);
    addStep(opDataRead,  'h1, 1, snoopMiss, 1, 0, stateE, busNone, snoopMiss, 0);
    addStep(opInstrRead, 'h1, 2, snoopHit,  0, 0, stateS, busRead, snoopMiss, 0);
    // Writes on E, on S, and a write miss into the first free way
    addStep(opDataWrite, 'h1, 1, snoopMiss, 1, 0, stateM, busNone,       snoopMiss, 0);
    addStep(opDataWrite, 'h1, 2, snoopMiss, 1, 0, stateM, busInvalidate, snoopMiss, 0);
    addStep(opDataWrite, 'h2, 1, snoopMiss, 0, 1, stateM, busRfo,        snoopMiss, 0);
    // Set 3 fills in way order, then two evictions by age
    addStep(opDataWrite, 'h10, 3, snoopMiss, 0, 0, stateM, busRfo, snoopMiss, 0);
    touchModel(0);
    dirtyModel[0] = 1'b1;
    for (int w = 1; w < ways; w++) begin
      addStep(opDataRead, 'h10 + w, 3, snoopMiss, 0, w, stateE, busRead, snoopMiss, 0);
      touchModel(w);
    end
    victimA = oldestModel();
    addStep(opDataRead, 'h14, 3, snoopMiss, 0, victimA, stateE, busRead, snoopMiss,
            dirtyModel[victimA]);
    dirtyModel[victimA] = 1'b0;
    touchModel(victimA);
    victimB = oldestModel();
    addStep(opDataRead, 'h15, 3, snoopMiss, 0, victimB, stateE, busRead, snoopMiss,
            dirtyModel[victimB]);
    touchModel(victimB);
    // Snoops
    addStep(opSnoopRead,       'h1,  1, snoopMiss, 1, 0,       stateS, busNone, snoopHitM, 0);
    addStep(opSnoopRead,       'h14, 3, snoopMiss, 1, victimA, stateS, busNone, snoopHit,  0);
    addStep(opSnoopRead,       'h99, 1, snoopMiss, 0, 0,       stateI, busNone, snoopMiss, 0);
    addStep(opSnoopRfo,        'h2,  1, snoopMiss, 1, 1,       stateI, busNone, snoopHitM, 0);
    addStep(opSnoopWrite,      'h1,  1, snoopMiss, 1, 0,       stateI, busNone, snoopHit,  0);
    addStep(opSnoopInvalidate, 'h15, 3, snoopMiss, 1, victimB, stateI, busNone, snoopHit,  0);
    addStep(opDataRead,        'h1,  1, snoopMiss, 0, 0,       stateE, busRead, snoopMiss, 0);
    addStep(opDataRead,        'h2,  1, snoopMiss, 0, 1,       stateE, busRead, snoopMiss, 0);
    // Clear, then former hits miss
    addStep(opClear,    'h0,  0, snoopMiss, 0, 0, stateI, busNone, snoopMiss, 0);
    addStep(opDataRead, 'h1,  2, snoopMiss, 0, 0, stateE, busRead, snoopMiss, 0);
    addStep(opDataRead, 'h12, 3, snoopMiss, 0, 0, stateE, busRead, snoopMiss, 0);
    addStep(opDataRead, 'h1,  1, snoopMiss, 0, 0, stateE, busRead, snoopMiss, 0);
    // Back-to-back burst to set 5
    burstStart = steps.size();
    addStep(opDataRead,  'h1, 5, snoopMiss, 0, 0, stateE, busRead, snoopMiss, 0);
    addStep(opDataWrite, 'h1, 5, snoopMiss, 1, 0, stateM, busNone, snoopMiss, 0);
    addStep(opDataRead,  'h2, 5, snoopMiss, 0, 1, stateE, busRead, snoopMiss, 0);
    addStep(opDataWrite, 'h2, 5, snoopMiss, 1, 1, stateM, busNone, snoopMiss, 0);
  endtask

  // ****************************************
  // Request and response processes
  // ****************************************
  task automatic waitCredit();
    int cycles;
    cycles = 0;
    while (sentCount - returnedCount >= queueDepth) begin
      if (cycles == timeoutCycles) reportTimeout("a returned credit");
      cycles++;
      waitCycle();
    end
  endtask

  task automatic waitDrained(int count);
    int cycles;
    cycles = 0;
    while (rspIdx < count) begin
      if (cycles == timeoutCycles) reportTimeout("earlier responses to drain");
      cycles++;
      waitCycle();
    end
  endtask

  task automatic sendAll();
    stepT s;
    for (int i = 0; i < steps.size(); i++) begin
      s = steps[i];
      if (i == burstStart) waitDrained(i);  // Full credits for the burst
      waitCredit();
      req.op      = s.op;
      req.addr    = {s.tag, s.set, 6'h0};
      req.snoopIn = s.snoopIn;
      reqValid    = 1'b1;
      sentCount++;
      waitCycle();
      reqValid    = 1'b0;
    end
  endtask

  task automatic waitResponse();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!rspValid) begin
      if (cycles == timeoutCycles) reportTimeout("a response");
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic checkAll();
    cacheRspT e;
    while (rspIdx < steps.size()) begin
      waitResponse();
      e       = steps[rspIdx].exp;
      curStep = rspIdx;
      checkEq("rsp.op",         32'(rsp.op),         32'(e.op));
      checkEq("rsp.hit",        32'(rsp.hit),        32'(e.hit));
      checkEq("rsp.way",        32'(rsp.way),        32'(e.way));
      checkEq("rsp.newState",   32'(rsp.newState),   32'(e.newState));
      checkEq("rsp.busOp",      32'(rsp.busOp),      32'(e.busOp));
      checkEq("rsp.snoopOut",   32'(rsp.snoopOut),   32'(e.snoopOut));
      checkEq("rsp.evictDirty", 32'(rsp.evictDirty), 32'(e.evictDirty));
      rspIdx++;
    end
  endtask

  task automatic waitCreditsBack();
    int cycles;
    cycles = 0;
    while (returnedCount < sentCount) begin
      if (cycles == timeoutCycles) reportTimeout("all credits to come back");
      cycles++;
      waitCycle();
    end
    curStep = rspIdx;
    checkEq("creditReturn count", 32'(returnedCount), 32'(sentCount));
  endtask

  initial begin
    arstN     = 1'b0;
    reqValid  = 1'b0;
    req       = '0;
    sentCount = 0;
    rspIdx    = 0;
    curStep   = 0;
    buildTable();
    repeat (4) @(posedge clk);
    #1;
    arstN = 1'b1;
    fork
      sendAll();
      checkAll();
    join
    waitCreditsBack();
    $display("Test OK");
    $finish;
  end

endmodule

//--- files.f
hw/l2CachePkg.sv
hw/requestQueue.sv
hw/tagLookup.sv
hw/lruTracker.sv
hw/mesiController.sv
hw/l2CacheTop.sv
verification/l2CacheTb.sv

//--- run.sh
#!/bin/sh
# Builds the L2 tag controller testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  -f files.f \
  --top-module l2CacheTb \
  -o l2CacheSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/l2CacheSim > sim.log 2>&1
simStatus=$?
cat sim.log

if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^Test OK$" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1
